//--- common/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B,
        ALU_LINK
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        logic      rd_wren;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic [2:0] funct3;
        alu_op_e   alu_op;
        logic      opb_imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // Also serves as the writeback bus
    typedef struct packed {
        logic      valid;
        logic      rd_wren;
        reg_addr_t rd;
        word_t     pc;
        word_t     data;
    } retire_t;

endpackage

//--- design/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  rv_pkg::redirect_t redirect_i,
    input  rv_pkg::word_t     instr_i,
    output rv_pkg::word_t     fetch_pc_o,
    output rv_pkg::if_id_t    if_id_o
);

    rv_pkg::word_t  pc_q;
    rv_pkg::word_t  pc_next;
    rv_pkg::if_id_t if_id_q;

    // Static not-taken prediction that execute overrides
    assign pc_next = redirect_i.taken ? redirect_i.target : pc_q + 32'd4;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // An all-zero word decodes as invalid, so clearing makes a bubble
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            if_id_q <= '0;
        end else if (redirect_i.taken) begin
            if_id_q <= '0;
        end else begin
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= instr_i;
        end
    end

    assign fetch_pc_o = pc_q;
    assign if_id_o    = if_id_q;

endmodule

//--- decode/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    input  rv_pkg::retire_t   wb_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o
);

    // x0 has no storage
    rv_pkg::word_t regs_q [1:31];
    logic          wr_en;

    assign wr_en = wb_i.valid && wb_i.rd_wren && (wb_i.rd != '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // Write-through covers a read in the same cycle as the write
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (wr_en && wb_i.rd == rs1_addr_i) ? wb_i.data : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (wr_en && wb_i.rd == rs2_addr_i) ? wb_i.data : regs_q[rs2_addr_i];

endmodule

//--- decode/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  rv_pkg::if_id_t    if_id_i,
    input  rv_pkg::redirect_t redirect_i,
    input  rv_pkg::retire_t   wb_i,
    output rv_pkg::id_ex_t    id_ex_o
);

    rv_pkg::word_t   instr;
    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv_pkg::word_t   rs1_data;
    rv_pkg::word_t   rs2_data;
    rv_pkg::id_ex_t  id_ex_d;
    rv_pkg::id_ex_t  id_ex_q;

    // alt selects SUB or SRA
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign instr  = if_id_i.instr;
    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    rv_regfile u_rv_regfile (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rs1_addr_i (instr[19:15]),
        .rs2_addr_i (instr[24:20]),
        .wb_i       (wb_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.funct3   = funct3;
        id_ex_d.alu_op   = rv_pkg::ALU_ADD;
        id_ex_d.rs1      = instr[19:15];
        id_ex_d.rs2      = instr[24:20];
        id_ex_d.rd       = instr[11:7];
        id_ex_d.pc       = if_id_i.pc;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        // I-type immediate unless overridden
        id_ex_d.imm      = {{20{instr[31]}}, instr[31:20]};

        case (opcode)
            rv_pkg::OP: begin
                id_ex_d.valid  = (funct7 == 7'b0000000) ||
                                 (funct7 == 7'b0100000 &&
                                  (funct3 == 3'b000 || funct3 == 3'b101));
                id_ex_d.alu_op = alu_sel(funct3, instr[30]);
            end
            rv_pkg::OP_IMM: begin
                // Shift immediates restrict funct7
                if (funct3 == 3'b001) begin
                    id_ex_d.valid = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    id_ex_d.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    id_ex_d.valid = 1'b1;
                end
                id_ex_d.alu_op  = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
                id_ex_d.opb_imm = 1'b1;
            end
            rv_pkg::LUI: begin
                id_ex_d.valid   = 1'b1;
                id_ex_d.alu_op  = rv_pkg::ALU_PASS_B;
                id_ex_d.opb_imm = 1'b1;
                id_ex_d.imm     = {instr[31:12], 12'b0};
            end
            rv_pkg::BRANCH: begin
                // BEQ, BNE, BLT, BGE only
                id_ex_d.valid     = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                                    (funct3 == 3'b100) || (funct3 == 3'b101);
                id_ex_d.is_branch = id_ex_d.valid;
                id_ex_d.imm       = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::JAL: begin
                id_ex_d.valid  = 1'b1;
                id_ex_d.is_jal = 1'b1;
                id_ex_d.alu_op = rv_pkg::ALU_LINK;
                id_ex_d.imm    = {{11{instr[31]}}, instr[31], instr[19:12],
                                  instr[20], instr[30:21], 1'b0};
            end
            rv_pkg::JALR: begin
                id_ex_d.valid   = (funct3 == 3'b000);
                id_ex_d.is_jalr = id_ex_d.valid;
                id_ex_d.alu_op  = rv_pkg::ALU_LINK;
            end
            default: id_ex_d.valid = 1'b0;
        endcase

        // Only branches lack a destination
        id_ex_d.rd_wren = id_ex_d.valid && (opcode != rv_pkg::BRANCH);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_ex_q <= '0;
        end else if (redirect_i.taken) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- execute/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  rv_pkg::id_ex_t    id_ex_i,
    output rv_pkg::redirect_t redirect_o,
    output rv_pkg::retire_t   retire_o
);

    rv_pkg::retire_t retire_q;
    rv_pkg::word_t   rs1_fwd;
    rv_pkg::word_t   rs2_fwd;
    rv_pkg::word_t   op_b;
    rv_pkg::word_t   alu_res;
    logic            br_cond;
    rv_pkg::word_t   jalr_sum;

    // The only producer one cycle ahead is the instruction in the retire register
    assign rs1_fwd = (retire_q.rd_wren && retire_q.rd == id_ex_i.rs1) ?
                     retire_q.data : id_ex_i.rs1_data;
    assign rs2_fwd = (retire_q.rd_wren && retire_q.rd == id_ex_i.rs2) ?
                     retire_q.data : id_ex_i.rs2_data;

    assign op_b = id_ex_i.opb_imm ? id_ex_i.imm : rs2_fwd;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_ADD:    alu_res = rs1_fwd + op_b;
            rv_pkg::ALU_SUB:    alu_res = rs1_fwd - op_b;
            rv_pkg::ALU_AND:    alu_res = rs1_fwd & op_b;
            rv_pkg::ALU_OR:     alu_res = rs1_fwd | op_b;
            rv_pkg::ALU_XOR:    alu_res = rs1_fwd ^ op_b;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_res = {31'b0, rs1_fwd < op_b};
            rv_pkg::ALU_SLL:    alu_res = rs1_fwd << op_b[4:0];
            rv_pkg::ALU_SRL:    alu_res = rs1_fwd >> op_b[4:0];
            rv_pkg::ALU_SRA:    alu_res = $signed(rs1_fwd) >>> op_b[4:0];
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = id_ex_i.pc + 32'd4;
        endcase
    end

    // Branch conditions by funct3
    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  br_cond = (rs1_fwd == rs2_fwd);
            3'b001:  br_cond = (rs1_fwd != rs2_fwd);
            3'b100:  br_cond = $signed(rs1_fwd) < $signed(rs2_fwd);
            3'b101:  br_cond = $signed(rs1_fwd) >= $signed(rs2_fwd);
            default: br_cond = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_fwd + id_ex_i.imm;

    // Flags are already low for bubbles and invalid words
    assign redirect_o.taken  = (id_ex_i.is_branch && br_cond) || id_ex_i.is_jal ||
                               id_ex_i.is_jalr;
    assign redirect_o.target = id_ex_i.is_jalr ? {jalr_sum[31:1], 1'b0} :
                               id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            retire_q <= '0;
        end else begin
            retire_q.valid   <= id_ex_i.valid;
            // Writes to x0 are dropped here
            retire_q.rd_wren <= id_ex_i.rd_wren && (id_ex_i.rd != '0);
            retire_q.rd      <= id_ex_i.rd;
            retire_q.pc      <= id_ex_i.pc;
            retire_q.data    <= alu_res;
        end
    end

    assign retire_o = retire_q;

endmodule

//--- design/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  rv_pkg::word_t   instr_i,
    output rv_pkg::word_t   fetch_pc_o,
    output rv_pkg::retire_t retire_o
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::redirect_t redirect;
    rv_pkg::retire_t   retire;

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_rv_fetch (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .redirect_i (redirect),
        .instr_i    (instr_i),
        .fetch_pc_o (fetch_pc_o),
        .if_id_o    (if_id)
    );

    // Retire bus doubles as the register file write port
    rv_decoder u_rv_decoder (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .if_id_i    (if_id),
        .redirect_i (redirect),
        .wb_i       (retire),
        .id_ex_o    (id_ex)
    );

    rv_execute u_rv_execute (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .id_ex_i    (id_ex),
        .redirect_o (redirect),
        .retire_o   (retire)
    );

    assign retire_o = retire;

endmodule

//--- tb/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input logic            clk_i,
    input logic            rst_ni,
    input rv_pkg::word_t   fetch_pc_i,
    input rv_pkg::retire_t retire_i
);

    // Edges since reset release saturating at three
    logic [1:0]  edges_q;
    int unsigned fail_count = 0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            edges_q <= '0;
        end else if (edges_q != 2'd3) begin
            edges_q <= edges_q + 2'd1;
        end
    end

    no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(retire_i.rd_wren && retire_i.rd == '0))
        else begin
            fail_count++;
            $error("retirement reports a write to x0");
        end

    // Pipeline is still filling, nothing may retire
    no_early_retire: assert property (@(posedge clk_i)
        (edges_q != 2'd3) |-> !retire_i.valid)
        else begin
            fail_count++;
            $error("retirement during reset or pipeline fill");
        end

    reset_pc: assert property (@(posedge clk_i)
        (rst_ni && edges_q == 2'd0) |-> fetch_pc_i == RESET_PC)
        else begin
            fail_count++;
            $error("fetch address after reset differs from RESET_PC");
        end

endmodule

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int WATCHDOG_CYCLES = 16 + 700 + 50;
    localparam int LAPS            = 3;

    logic            clk_i;
    logic            rst_ni;
    rv_pkg::word_t   instr;
    rv_pkg::word_t   fetch_pc;
    rv_pkg::retire_t retire;
    rv_pkg::word_t   mem [0:63];
    rv_pkg::word_t   model_regs [0:31];
    rv_pkg::word_t   model_pc;
    logic [31:0]     lfsr_q;
    int              errors;
    int              checks;
    int              laps;
    int              prop_fails;

    rv_core_top #(
        .RESET_PC ('0)
    ) u_rv_core_top (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .instr_i    (instr),
        .fetch_pc_o (fetch_pc),
        .retire_o   (retire)
    );

    bind rv_core_top rv_core_properties #(
        .RESET_PC (RESET_PC)
    ) u_rv_core_properties (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .fetch_pc_i (fetch_pc_o),
        .retire_i   (retire_o)
    );

    // Instruction memory answers in the same cycle
    assign instr = mem[fetch_pc[7:2]];

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic supported(input logic [31:0] ins);
        case (ins[6:0])
            7'b0110011, 7'b0010011, 7'b0110111,
            7'b1100011, 7'b1101111, 7'b1100111: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic gen_program();
        logic [31:0] kind;
        logic [31:0] f3;
        logic [31:0] k;
        logic [31:0] off;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [6:0]  f7;
        prev_rd = 5'd1;
        for (int i = 0; i < 63; i++) begin
            rd   = 5'(rand_bits(5));
            // Sources often reuse the last destination
            rs1  = rand_bits(1) ? prev_rd : 5'(rand_bits(5));
            rs2  = rand_bits(1) ? prev_rd : 5'(rand_bits(5));
            f3   = rand_bits(3);
            kind = (i == 0) ? 32'd6 : rand_bits(4);
            k    = 32'd1 + rand_bits(2);
            if (i + k > 63) begin
                k = 63 - i;
            end
            off = 4 * k;
            imm = rand_bits(25);
            if (i == 1) begin
                // Load opcode outside the kept subset
                mem[i] = {imm[24:0], 7'b0000011};
            end else if (kind < 6) begin
                f7     = (rand_bits(1) && (f3 == 0 || f3 == 5)) ? 7'b0100000 : 7'b0;
                mem[i] = {f7, rs2, rs1, f3[2:0], rd, 7'b0110011};
            end else if (kind < 10 || kind == 15) begin
                if (f3 == 1) begin
                    imm[11:5] = 7'b0;
                end else if (f3 == 5) begin
                    imm[11:5] = rand_bits(1) ? 7'b0100000 : 7'b0;
                end
                mem[i] = {imm[11:0], rs1, f3[2:0], rd, 7'b0010011};
            end else if (kind == 10) begin
                mem[i] = {imm[19:0], rd, 7'b0110111};
            end else if (kind < 13) begin
                mem[i] = {off[12], off[10:5], rs2, rs1, f3[1], 1'b0, f3[0],
                          off[4:1], off[11], 7'b1100011};
            end else if (kind == 13) begin
                mem[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            end else begin
                off    = 4 * (i + k);
                mem[i] = {off[11:0], 5'd0, 3'b000, rd, 7'b1100111};
            end
            prev_rd = rd;
        end
        // Last word jumps back to the start
        off     = 32'd0 - 32'd252;
        mem[63] = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endtask

    task automatic model_retire(input rv_pkg::retire_t r);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        logic        alt;
        logic        wr;
        logic        take;
        while (!supported(mem[model_pc[7:2]])) begin
            model_pc = model_pc + 32'd4;
        end
        ins     = mem[model_pc[7:2]];
        f3      = ins[14:12];
        a       = model_regs[ins[19:15]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        b       = (ins[6:0] == 7'b0110011) ? model_regs[ins[24:20]] : imm_i;
        alt     = ins[30] && (ins[6:0] == 7'b0110011 || f3 == 3'b101);
        next_pc = model_pc + 32'd4;
        wr      = 1'b1;
        res     = '0;
        take    = 1'b0;
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                case (f3)
                    3'b000:  res = alt ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b100:  res = a ^ b;
                    3'b101: begin
                        if (alt) begin
                            res = $signed(a) >>> b[4:0];
                        end else begin
                            res = a >> b[4:0];
                        end
                    end
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b1101111: begin
                res     = model_pc + 32'd4;
                next_pc = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
            end
            7'b1100111: begin
                res     = model_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: begin
                wr = 1'b0;
                b  = model_regs[ins[24:20]];
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = $signed(a) < $signed(b);
                    default: take = $signed(a) >= $signed(b);
                endcase
                if (take) begin
                    next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
                end
            end
        endcase
        wr = wr && (ins[11:7] != 5'd0);
        assert (r.pc == model_pc)
            else flag_error($sformatf("retired pc %h, expected %h", r.pc, model_pc));
        assert (r.rd_wren == wr)
            else flag_error($sformatf("pc %h write enable %b, expected %b", r.pc, r.rd_wren, wr));
        if (wr) begin
            assert (r.rd == ins[11:7] && r.data == res)
                else flag_error($sformatf("pc %h wrote x%0d=%h, expected x%0d=%h",
                                          r.pc, r.rd, r.data, ins[11:7], res));
            model_regs[ins[11:7]] = res;
        end
        model_pc = next_pc;
        checks++;
    endtask

    // Checking stops once the last lap has retired
    always @(negedge clk_i) begin
        if (rst_ni && retire.valid && laps < LAPS) begin
            model_retire(retire);
            if (retire.pc == 32'd252) begin
                laps++;
            end
        end
    end

    initial begin
        rst_ni   = 1'b0;
        lfsr_q   = 32'd99063;
        errors   = 0;
        checks   = 0;
        laps     = 0;
        model_pc = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        gen_program();
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        while (laps < LAPS) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        prop_fails = u_rv_core_top.u_rv_core_properties.fail_count;
        $display("Retired %0d, check errors %0d, assertion failures %0d",
                 checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0 && checks > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the program did not finish its laps within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- list.f
common/rv_pkg.sv
design/rv_fetch.sv
decode/rv_regfile.sv
decode/rv_decoder.sv
execute/rv_execute.sv
design/rv_core_top.sv
tb/rv_core_properties.sv
tb/tb_rv_core.sv

//--- Makefile
# Verilator flow for the RV32I pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
